//--- logic/crc_ahb_pkg.sv
////////////////////////////////////////////////////////////
// Shared definitions for the AHB-Lite CRC accelerator.
// Holds the register map, bus encodings, reset values and
// the width types used by the RTL and the testbench.
// Import it with a wildcard inside a module body.
////////////////////////////////////////////////////////////
package crc_ahb_pkg;

	// Bus and CRC word, transfer size, register index
	typedef logic [31:0] word_t;
	typedef logic [1:0]  size_t;
	typedef logic [2:0]  reg_addr_t;

	// CR field types
	typedef logic [1:0] poly_size_t;
	typedef logic [1:0] rev_in_t;

	// Register indices, HADDR[4:2]
	localparam reg_addr_t CRC_DR   = 3'h0;
	localparam reg_addr_t CRC_IDR  = 3'h1;
	localparam reg_addr_t CRC_CR   = 3'h2;
	localparam reg_addr_t CRC_INIT = 3'h4;
	localparam reg_addr_t CRC_POL  = 3'h5;

	// HTRANS encoding
	localparam logic [1:0] IDLE    = 2'b00;
	localparam logic [1:0] BUSY    = 2'b01;
	localparam logic [1:0] NON_SEQ = 2'b10;
	localparam logic [1:0] SEQ     = 2'b11;

	// Only OKAY is ever returned
	localparam logic HRESP_OKAY = 1'b0;

	// Reset values
	localparam logic [4:0] RESET_CRC_CR   = 5'h00;
	localparam word_t      RESET_CRC_INIT = 32'hFFFF_FFFF;
	localparam word_t      RESET_CRC_POL  = 32'h04C1_1DB7;

	// Transfer size codes, low bits of HSIZE
	localparam size_t SIZE_BYTE = 2'd0;
	localparam size_t SIZE_HALF = 2'd1;
	localparam size_t SIZE_WORD = 2'd2;

	// Polynomial width codes
	localparam poly_size_t POLY_32 = 2'd0;
	localparam poly_size_t POLY_16 = 2'd1;
	localparam poly_size_t POLY_8  = 2'd2;
	localparam poly_size_t POLY_7  = 2'd3;

	// Input reversal codes
	localparam rev_in_t REV_NONE = 2'd0;
	localparam rev_in_t REV_BYTE = 2'd1;
	localparam rev_in_t REV_HALF = 2'd2;
	localparam rev_in_t REV_WORD = 2'd3;

	// Engine FSM
	typedef enum logic [1:0] {ENG_IDLE, ENG_SHIFT, ENG_RELOAD} engine_state_t;

endpackage

//--- logic/crc_byte_stream_if.sv
////////////////////////////////////////////////////////////
// One buffered DR write moving from the input buffer to the
// CRC engine. A transfer happens when valid and ready are high.
////////////////////////////////////////////////////////////
interface crc_byte_stream_if;
	import crc_ahb_pkg::*;

	// Payload held stable while valid waits for ready
	word_t data;
	size_t size;
	logic  valid;
	logic  ready;

	// Buffer side
	modport source (output data, output size, output valid, input ready);

	// Engine side
	modport sink (input data, input size, input valid, output ready);

endinterface

//--- logic/host_interface.sv
////////////////////////////////////////////////////////////
// AHB-Lite slave front end of the CRC accelerator.
// Registers the address phase, decodes the five registers,
// holds CR, drives the read mux and stalls on back-pressure
// from the buffer and the engine.
////////////////////////////////////////////////////////////
module host_interface
(
	input  logic                    HCLK,
	input  logic                    HRESETn,
	input  logic                    HSElx,
	input  crc_ahb_pkg::word_t      HADDR,
	input  logic [1:0]              HTRANS,
	input  logic                    HWRITE,
	input  logic [2:0]              HSIZE,
	input  crc_ahb_pkg::word_t      HWDATA,
	input  logic                    HREADY,
	input  crc_ahb_pkg::word_t      crc_out,
	input  crc_ahb_pkg::word_t      crc_init_out,
	input  crc_ahb_pkg::word_t      crc_poly_out,
	input  logic [7:0]              crc_idr_out,
	input  logic                    buffer_full,
	input  logic                    reset_pending,
	input  logic                    read_wait,
	output crc_ahb_pkg::word_t      HRDATA,
	output logic                    HREADYOUT,
	output logic                    HRESP,
	output crc_ahb_pkg::word_t      bus_wr,
	output crc_ahb_pkg::size_t      bus_size,
	output crc_ahb_pkg::poly_size_t crc_poly_size,
	output crc_ahb_pkg::rev_in_t    rev_in_type,
	output logic                    rev_out_type,
	output logic                    buffer_write_en,
	output logic                    crc_init_en,
	output logic                    crc_idr_en,
	output logic                    crc_poly_en,
	output logic                    reset_chain
);
	import crc_ahb_pkg::*;

	// Address phase pipeline
	reg_addr_t  haddr_q;
	size_t      hsize_q;
	logic [1:0] htrans_q;
	logic       hwrite_q;
	logic       hsel_q;

	// Control register: [4] rev out, [3:2] rev in, [1:0] poly size
	logic [4:0] crc_cr_q;

	logic  sample_bus;
	logic  xfer_valid;
	logic  write_en;
	logic  read_en;
	logic  dr_sel;
	logic  idr_sel;
	logic  cr_sel;
	logic  init_sel;
	logic  pol_sel;
	logic  dr_write;
	logic  dr_read;
	logic  init_write;
	logic  crc_cr_en;
	word_t crc_cr_rd;

	// Address phase is taken when the bus moves on
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hsel_q   <= 1'b0;
			htrans_q <= IDLE;
		end
		else if (sample_bus)
		begin
			haddr_q  <= HADDR[4:2];
			hsize_q  <= HSIZE[1:0];
			htrans_q <= HTRANS;
			hwrite_q <= HWRITE;
			hsel_q   <= HSElx;
		end
	end

	// Bursts behave as singles, IDLE and BUSY are ignored
	assign xfer_valid = hsel_q && ((htrans_q == NON_SEQ) || (htrans_q == SEQ));
	assign write_en   = xfer_valid && hwrite_q;
	assign read_en    = xfer_valid && !hwrite_q;

	// Register decode
	assign dr_sel   = (haddr_q == CRC_DR);
	assign idr_sel  = (haddr_q == CRC_IDR);
	assign cr_sel   = (haddr_q == CRC_CR);
	assign init_sel = (haddr_q == CRC_INIT);
	assign pol_sel  = (haddr_q == CRC_POL);

	assign dr_write   = dr_sel && write_en;
	assign dr_read    = dr_sel && read_en;
	assign init_write = init_sel && write_en;

	////////////////////////////////////////////////////////////
	// Stall and write enables
	////////////////////////////////////////////////////////////

	// Data phase held while the target cannot take it
	assign HREADYOUT = !((dr_write && buffer_full) ||
	                     (dr_read && read_wait) ||
	                     (init_write && reset_pending));
	assign HRESP = HRESP_OKAY;

	// Enables fire only on the completing cycle of the phase
	assign buffer_write_en = dr_write && !buffer_full;
	assign crc_init_en     = init_write && !reset_pending;
	assign crc_idr_en      = idr_sel && write_en;
	assign crc_poly_en     = pol_sel && write_en;
	assign crc_cr_en       = cr_sel && write_en;

	// Write data comes straight from the bus
	assign bus_wr   = HWDATA;
	assign bus_size = hsize_q;

	// CR fields sit in HWDATA[7:3], bit 0 asks for a reload
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_cr_q <= RESET_CRC_CR;
		else if (crc_cr_en)
			crc_cr_q <= HWDATA[7:3];
	end

	assign reset_chain   = crc_cr_en && HWDATA[0];
	assign crc_poly_size = crc_cr_q[1:0];
	assign rev_in_type   = crc_cr_q[3:2];
	assign rev_out_type  = crc_cr_q[4];

	////////////////////////////////////////////////////////////
	// Read mux
	////////////////////////////////////////////////////////////

	assign crc_cr_rd = {24'h0, crc_cr_q, 3'h0};

	// One-hot select, unmapped indices read zero
	assign HRDATA = ({32{dr_sel}}   & crc_out) |
	                ({32{init_sel}} & crc_init_out) |
	                ({32{idr_sel}}  & {24'h0, crc_idr_out}) |
	                ({32{pol_sel}}  & crc_poly_out) |
	                ({32{cr_sel}}   & crc_cr_rd);

endmodule

//--- logic/crc_input_buffer.sv
////////////////////////////////////////////////////////////
// One-entry holding register for DR writes.
// Offers the held word and its size to the engine and
// reports full so the host stalls the next DR write.
////////////////////////////////////////////////////////////
module crc_input_buffer
(
	input  logic               HCLK,
	input  logic               HRESETn,
	input  crc_ahb_pkg::word_t bus_wr,
	input  crc_ahb_pkg::size_t bus_size,
	input  logic               buffer_write_en,
	output logic               buffer_full,
	crc_byte_stream_if.source  stream
);
	import crc_ahb_pkg::*;

	// Held write
	word_t data_q;
	size_t size_q;

	// Entry occupied
	logic valid_q;

	logic take;

	// Engine takes the entry on this edge
	assign take = valid_q && stream.ready;

	////////////////////////////////////////////////////////////
	// Occupancy
	////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			valid_q <= 1'b0;
		else if (buffer_write_en)
			valid_q <= 1'b1;
		else if (take)
			valid_q <= 1'b0;
	end

	// Payload, only loaded with a new write
	always_ff @(posedge HCLK)
	begin
		if (buffer_write_en)
		begin
			data_q <= bus_wr;
			size_q <= bus_size;
		end
	end

	// Stream side
	assign stream.data  = data_q;
	assign stream.size  = size_q;
	assign stream.valid = valid_q;

	// Full as long as the entry waits for the engine
	assign buffer_full = valid_q;

endmodule

//--- logic/crc_engine.sv
////////////////////////////////////////////////////////////
// Serial CRC engine with the POL, INIT and IDR registers.
// Folds one byte per clock, low byte first, MSB first within
// the byte, and reloads the CRC from INIT on request.
////////////////////////////////////////////////////////////
module crc_engine
(
	input  logic                    HCLK,
	input  logic                    HRESETn,
	input  crc_ahb_pkg::word_t      bus_wr,
	input  logic                    crc_init_en,
	input  logic                    crc_poly_en,
	input  logic                    crc_idr_en,
	input  logic                    reset_chain,
	input  crc_ahb_pkg::poly_size_t crc_poly_size,
	input  crc_ahb_pkg::rev_in_t    rev_in_type,
	input  logic                    rev_out_type,
	input  logic                    buffer_full,
	output crc_ahb_pkg::word_t      crc_out,
	output crc_ahb_pkg::word_t      crc_init_out,
	output crc_ahb_pkg::word_t      crc_poly_out,
	output logic [7:0]              crc_idr_out,
	output logic                    reset_pending,
	output logic                    read_wait,
	crc_byte_stream_if.sink         stream
);
	import crc_ahb_pkg::*;

	engine_state_t state_q;
	word_t         crc_q;
	word_t         init_q;
	word_t         poly_q;
	logic [7:0]    idr_q;
	logic          reload_q;
	word_t         data_q;
	logic [1:0]    last_q;
	logic [1:0]    byte_idx_q;
	word_t         width_mask;
	logic [4:0]    msb;
	logic [4:0]    out_shift;
	word_t         crc_masked;

	// Bit reversal within bytes, half-words or the whole word
	function automatic word_t reverse_bits(word_t w, rev_in_t mode);
		word_t r;
		r = w;
		for (int i = 0; i < 32; i++)
		begin
			case (mode)
				REV_BYTE: r[i] = w[(i & ~7) | (7 - (i & 7))];
				REV_HALF: r[i] = w[(i & ~15) | (15 - (i & 15))];
				REV_WORD: r[i] = w[31 - i];
				default:  r[i] = w[i];
			endcase
		end
		return r;
	endfunction

	// One byte through the MSB-first shift register
	function automatic word_t crc_byte(word_t crc_in, logic [7:0] din, word_t poly,
	                                   word_t mask, logic [4:0] top);
		word_t crc;
		logic  fb;
		crc = crc_in;
		for (int i = 7; i >= 0; i--)
		begin
			fb  = crc[top] ^ din[i];
			crc = (crc << 1) & mask;
			if (fb)
				crc = crc ^ (poly & mask);
		end
		return crc;
	endfunction

	// Width decode: mask, top bit and output reversal shift
	always_comb
	begin
		case (crc_poly_size)
			POLY_16:
			begin
				width_mask = 32'h0000_FFFF;
				msb        = 5'd15;
				out_shift  = 5'd16;
			end
			POLY_8:
			begin
				width_mask = 32'h0000_00FF;
				msb        = 5'd7;
				out_shift  = 5'd24;
			end
			POLY_7:
			begin
				width_mask = 32'h0000_007F;
				msb        = 5'd6;
				out_shift  = 5'd25;
			end
			default:
			begin
				width_mask = 32'hFFFF_FFFF;
				msb        = 5'd31;
				out_shift  = 5'd0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Configuration registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_q <= RESET_CRC_INIT;
			poly_q <= RESET_CRC_POL;
			idr_q  <= 8'h00;
		end
		else
		begin
			if (crc_init_en)
				init_q <= bus_wr;
			if (crc_poly_en)
				poly_q <= bus_wr;
			if (crc_idr_en)
				idr_q <= bus_wr[7:0];
		end
	end

	// Reload request waits until the engine gets to it
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			reload_q <= 1'b0;
		else if (reset_chain)
			reload_q <= 1'b1;
		else if (state_q == ENG_RELOAD)
			reload_q <= 1'b0;
	end

	////////////////////////////////////////////////////////////
	// Engine FSM
	////////////////////////////////////////////////////////////

	assign stream.ready = (state_q == ENG_IDLE);

	// Accepted word, already reversed, and its last byte index
	always_ff @(posedge HCLK)
	begin
		if (stream.valid && stream.ready)
		begin
			data_q <= reverse_bits(stream.data, rev_in_type);
			last_q <= (stream.size == SIZE_BYTE) ? 2'd0 :
			          (stream.size == SIZE_HALF) ? 2'd1 : 2'd3;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state_q    <= ENG_IDLE;
			byte_idx_q <= 2'd0;
			crc_q      <= RESET_CRC_INIT;
		end
		else
		begin
			case (state_q)
				ENG_IDLE:
				begin
					byte_idx_q <= 2'd0;
					// Waiting data goes before a reload
					if (stream.valid)
						state_q <= ENG_SHIFT;
					else if (reload_q && !buffer_full)
						state_q <= ENG_RELOAD;
				end
				ENG_SHIFT:
				begin
					crc_q <= crc_byte(crc_q, data_q[{byte_idx_q, 3'b000} +: 8], poly_q,
					                  width_mask, msb);
					byte_idx_q <= byte_idx_q + 2'd1;
					if (byte_idx_q == last_q)
						state_q <= ENG_IDLE;
				end
				ENG_RELOAD:
				begin
					crc_q   <= init_q;
					state_q <= ENG_IDLE;
				end
				default:
					state_q <= ENG_IDLE;
			endcase
		end
	end

	// Result masked to width, optionally mirrored across it
	assign crc_masked = crc_q & width_mask;
	assign crc_out    = rev_out_type ? (reverse_bits(crc_masked, REV_WORD) >> out_shift) :
	                    crc_masked;

	assign crc_init_out  = init_q;
	assign crc_poly_out  = poly_q;
	assign crc_idr_out   = idr_q;
	assign reset_pending = reload_q;
	assign read_wait     = buffer_full || (state_q != ENG_IDLE);

endmodule

//--- logic/crc_ahb_top.sv
////////////////////////////////////////////////////////////
// CRC accelerator top level on plain AHB-Lite slave ports.
// Connects the host interface, input buffer and CRC engine.
////////////////////////////////////////////////////////////
module crc_ahb_top
(
	input  logic               HCLK,
	input  logic               HRESETn,
	input  logic               HSElx,
	input  crc_ahb_pkg::word_t HADDR,
	input  logic [1:0]         HTRANS,
	input  logic               HWRITE,
	input  logic [2:0]         HSIZE,
	input  crc_ahb_pkg::word_t HWDATA,
	input  logic               HREADY,
	output crc_ahb_pkg::word_t HRDATA,
	output logic               HREADYOUT,
	output logic               HRESP
);
	import crc_ahb_pkg::*;

	// Host to buffer and engine
	word_t      bus_wr;
	size_t      bus_size;
	poly_size_t crc_poly_size;
	rev_in_t    rev_in_type;
	logic       rev_out_type;
	logic       buffer_write_en;
	logic       crc_init_en;
	logic       crc_idr_en;
	logic       crc_poly_en;
	logic       reset_chain;

	// Engine and buffer back to host
	word_t      crc_out;
	word_t      crc_init_out;
	word_t      crc_poly_out;
	logic [7:0] crc_idr_out;
	logic       buffer_full;
	logic       reset_pending;
	logic       read_wait;

	// Buffered write toward the engine
	crc_byte_stream_if stream_if ();

	host_interface host_interface_i
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.HSElx           (HSElx),
		.HADDR           (HADDR),
		.HTRANS          (HTRANS),
		.HWRITE          (HWRITE),
		.HSIZE           (HSIZE),
		.HWDATA          (HWDATA),
		.HREADY          (HREADY),
		.crc_out         (crc_out),
		.crc_init_out    (crc_init_out),
		.crc_poly_out    (crc_poly_out),
		.crc_idr_out     (crc_idr_out),
		.buffer_full     (buffer_full),
		.reset_pending   (reset_pending),
		.read_wait       (read_wait),
		.HRDATA          (HRDATA),
		.HREADYOUT       (HREADYOUT),
		.HRESP           (HRESP),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.crc_poly_size   (crc_poly_size),
		.rev_in_type     (rev_in_type),
		.rev_out_type    (rev_out_type),
		.buffer_write_en (buffer_write_en),
		.crc_init_en     (crc_init_en),
		.crc_idr_en      (crc_idr_en),
		.crc_poly_en     (crc_poly_en),
		.reset_chain     (reset_chain)
	);

	crc_input_buffer crc_input_buffer_i
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.buffer_write_en (buffer_write_en),
		.buffer_full     (buffer_full),
		.stream          (stream_if.source)
	);

	crc_engine crc_engine_i
	(
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.bus_wr        (bus_wr),
		.crc_init_en   (crc_init_en),
		.crc_poly_en   (crc_poly_en),
		.crc_idr_en    (crc_idr_en),
		.reset_chain   (reset_chain),
		.crc_poly_size (crc_poly_size),
		.rev_in_type   (rev_in_type),
		.rev_out_type  (rev_out_type),
		.buffer_full   (buffer_full),
		.crc_out       (crc_out),
		.crc_init_out  (crc_init_out),
		.crc_poly_out  (crc_poly_out),
		.crc_idr_out   (crc_idr_out),
		.reset_pending (reset_pending),
		.read_wait     (read_wait),
		.stream        (stream_if.sink)
	);

endmodule

//--- verification/crc_ahb_checker.sv
////////////////////////////////////////////////////////////
// Bus-side checker for the CRC accelerator testbench.
// Follows AHB transfers at the top-level ports, compares
// every completed read with the next queued expected value
// and keeps the pass and fail counts.
////////////////////////////////////////////////////////////
module crc_ahb_checker
(
	input logic               HCLK,
	input logic               HRESETn,
	input logic               HSElx,
	input logic [1:0]         HTRANS,
	input logic               HWRITE,
	input logic               HREADY,
	input logic               HREADYOUT,
	input logic               HRESP,
	input crc_ahb_pkg::word_t HRDATA
);
	import crc_ahb_pkg::*;

	// Expected read data, oldest first
	word_t expect_q[$];

	// Totals and per-test counts
	int pass_count = 0;
	int fail_count = 0;
	int test_pass  = 0;
	int test_fail  = 0;

	logic  read_phase = 1'b0;
	logic  resp_seen  = 1'b0;
	word_t exp_v;

	// Queue the value the next read must return
	task automatic expect_read(input word_t value);
		expect_q.push_back(value);
	endtask

	// Summary for the test that just ended
	task automatic test_done(input string name);
		$display("%-20s %0d reads checked, %0d errors", name, test_pass + test_fail, test_fail);
		test_pass = 0;
		test_fail = 0;
	endtask

	////////////////////////////////////////////////////////////
	// Data phase monitor
	////////////////////////////////////////////////////////////

	// Mid-cycle sampling, inputs and outputs are settled here
	always @(negedge HCLK)
	begin
		if (!HRESETn)
			read_phase <= 1'b0;
		else
		begin
			// HRESP must stay OKAY, reported once
			if (HRESP !== HRESP_OKAY && !resp_seen)
			begin
				$display("[FAIL] HRESP expected %0h got %0h", HRESP_OKAY, HRESP);
				resp_seen = 1'b1;
				fail_count++;
				test_fail++;
			end
			// Completion of one phase is also the next address phase
			if (HREADY && HREADYOUT)
			begin
				if (read_phase)
				begin
					if (expect_q.size() == 0)
					begin
						$display("A read completed with no expected value queued");
						fail_count++;
						test_fail++;
					end
					else
					begin
						exp_v = expect_q.pop_front();
						if (HRDATA !== exp_v)
						begin
							$display("[FAIL] HRDATA expected %08h got %08h", exp_v, HRDATA);
							fail_count++;
							test_fail++;
						end
						else
						begin
							pass_count++;
							test_pass++;
						end
					end
				end
				read_phase <= HSElx && !HWRITE && ((HTRANS == NON_SEQ) || (HTRANS == SEQ));
			end
		end
	end

endmodule

//--- verification/crc_ahb_tb.sv
////////////////////////////////////////////////////////////
// Testbench for the AHB-Lite CRC accelerator.
// AHB master tasks drive register and DR traffic, a reference
// CRC model predicts DR reads and the checker compares them.
////////////////////////////////////////////////////////////
module crc_ahb_tb;
	import crc_ahb_pkg::*;

	logic       HCLK;
	logic       HRESETn;
	logic       HSElx;
	word_t      HADDR;
	logic [1:0] HTRANS;
	logic       HWRITE;
	logic [2:0] HSIZE;
	word_t      HWDATA;
	logic       HREADY;
	word_t      HRDATA;
	logic       HREADYOUT;
	logic       HRESP;

	// Model state, raw CRC register and register copies
	word_t      crc_raw;
	word_t      init_val;
	word_t      poly_val;
	logic [4:0] cr_val;
	word_t      expected_dr;
	word_t      w;
	logic       aborted;
	int         seed;

	// Only one slave, so the bus ready is its own
	assign HREADY = HREADYOUT;

	crc_ahb_top crc_ahb_top_i (.*);

	crc_ahb_checker crc_ahb_checker_i (.*);

	initial
	begin
		HCLK = 1'b0;
		forever #5 HCLK = ~HCLK;
	end

	// Expected DR value after one write, next_raw is the register
	function automatic word_t crc_model(input word_t prev, input word_t data, input size_t size,
	                                    input word_t poly, input logic [4:0] cr,
	                                    output word_t next_raw);
		word_t rin;
		word_t reg_v;
		word_t mask;
		word_t result;
		int    width;
		int    nbytes;
		logic  fb;
		width  = (cr[1:0] == POLY_32) ? 32 : (cr[1:0] == POLY_16) ? 16 :
		         (cr[1:0] == POLY_8) ? 8 : 7;
		mask   = (width == 32) ? 32'hFFFF_FFFF : ((32'h1 << width) - 32'h1);
		nbytes = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
		// Input mirrored within lanes of 8, 16 or 32 bits
		for (int i = 0; i < 32; i++)
			case (cr[3:2])
				REV_BYTE: rin[i] = data[8 * (i / 8) + 7 - i % 8];
				REV_HALF: rin[i] = data[16 * (i / 16) + 15 - i % 16];
				REV_WORD: rin[i] = data[31 - i];
				default:  rin[i] = data[i];
			endcase
		// Low byte first, MSB first within it
		reg_v = prev;
		for (int b = 0; b < nbytes; b++)
			for (int k = 7; k >= 0; k--)
			begin
				fb    = reg_v[width - 1] ^ rin[8 * b + k];
				reg_v = (reg_v << 1) & mask;
				if (fb)
					reg_v = reg_v ^ (poly & mask);
			end
		next_raw = reg_v;
		result   = reg_v;
		// Output mirrored across the width
		if (cr[4])
			for (int i = 0; i < width; i++)
				result[i] = reg_v[width - 1 - i];
		return result;
	endfunction

	////////////////////////////////////////////////////////////
	// AHB master
	////////////////////////////////////////////////////////////

	task automatic address_phase(input reg_addr_t idx, input logic write, input logic [2:0] size);
		HSElx  = 1'b1;
		HADDR  = {27'h0, idx, 2'b00};
		HTRANS = NON_SEQ;
		HWRITE = write;
		HSIZE  = size;
		@(posedge HCLK);
		#1;
		HSElx  = 1'b0;
		HTRANS = IDLE;
	endtask

	// Data phase ends on the first edge with HREADYOUT high
	task automatic wait_ready(input reg_addr_t idx);
		int cycles;
		cycles = 0;
		@(negedge HCLK);
		while (!HREADYOUT && cycles < 200)
		begin
			@(negedge HCLK);
			cycles++;
		end
		if (!HREADYOUT)
		begin
			$display("Timeout: HREADYOUT stayed low for 200 cycles on register %0d", idx);
			aborted = 1'b1;
		end
		@(posedge HCLK);
		#1;
	endtask

	task automatic ahb_write(input reg_addr_t idx, input word_t data, input logic [2:0] size);
		if (!aborted)
		begin
			address_phase(idx, 1'b1, size);
			HWDATA = data;
			wait_ready(idx);
		end
	endtask

	task automatic ahb_read(input reg_addr_t idx, input word_t expected);
		if (!aborted)
		begin
			crc_ahb_checker_i.expect_read(expected);
			address_phase(idx, 1'b0, 3'b010);
			wait_ready(idx);
		end
	endtask

	// DR write, model follows along
	task automatic dr_write(input word_t data, input size_t size);
		ahb_write(CRC_DR, data, {1'b0, size});
		expected_dr = crc_model(crc_raw, data, size, poly_val, cr_val, crc_raw);
	endtask

	// Fields {rev out, rev in, width}, bit 0 asks for a reload
	task automatic set_cr(input logic [4:0] fields, input logic reload);
		ahb_write(CRC_CR, {24'h0, fields, 2'b00, reload}, 3'b010);
		cr_val = fields;
		if (reload)
			crc_raw = init_val;
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial
	begin
		seed = 48600;
		void'($urandom(seed));
		HRESETn  = 1'b0;
		HSElx    = 1'b0;
		HADDR    = '0;
		HTRANS   = IDLE;
		HWRITE   = 1'b0;
		HSIZE    = 3'b010;
		HWDATA   = '0;
		aborted  = 1'b0;
		crc_raw  = RESET_CRC_INIT;
		init_val = RESET_CRC_INIT;
		poly_val = RESET_CRC_POL;
		cr_val   = RESET_CRC_CR;
		repeat (16) @(posedge HCLK);
		#1;
		HRESETn = 1'b1;

		ahb_read(CRC_CR, {24'h0, RESET_CRC_CR, 3'h0});
		ahb_read(CRC_INIT, RESET_CRC_INIT);
		ahb_read(CRC_POL, RESET_CRC_POL);
		crc_ahb_checker_i.test_done("reset values");

		set_cr(5'h00, 1'b1);
		repeat (8) dr_write($urandom, SIZE_WORD);
		ahb_read(CRC_DR, expected_dr);
		crc_ahb_checker_i.test_done("default CRC-32");

		// Random polynomial per width, mixed transfer sizes
		for (int ps = 0; ps < 4; ps++)
		begin
			poly_val = $urandom;
			ahb_write(CRC_POL, poly_val, 3'b010);
			set_cr({3'b000, 2'(ps)}, 1'b1);
			repeat (6) dr_write($urandom, size_t'($urandom % 3));
			ahb_read(CRC_DR, expected_dr);
		end
		crc_ahb_checker_i.test_done("polynomial widths");

		// rv gives rev out and rev in, the width follows rev in
		poly_val = RESET_CRC_POL;
		ahb_write(CRC_POL, poly_val, 3'b010);
		for (int rv = 0; rv < 8; rv++)
		begin
			set_cr(5'(rv * 4 + rv % 4), 1'b1);
			repeat (4) dr_write($urandom, size_t'($urandom % 3));
			ahb_read(CRC_DR, expected_dr);
		end
		crc_ahb_checker_i.test_done("bit reversal");

		// Stalled writes and read, then INIT behind a pending reload
		set_cr(5'h00, 1'b1);
		repeat (3) dr_write($urandom, SIZE_WORD);
		ahb_read(CRC_DR, expected_dr);
		repeat (3) dr_write($urandom, SIZE_WORD);
		set_cr(5'h00, 1'b1);
		w = $urandom;
		ahb_write(CRC_INIT, w, 3'b010);
		init_val = w;
		repeat (2) dr_write($urandom, SIZE_WORD);
		ahb_read(CRC_DR, expected_dr);
		set_cr(5'h00, 1'b1);
		repeat (2) dr_write($urandom, SIZE_WORD);
		ahb_read(CRC_DR, expected_dr);
		ahb_read(CRC_INIT, init_val);
		crc_ahb_checker_i.test_done("stall and reload");

		repeat (8)
		begin
			w = $urandom;
			ahb_write(CRC_IDR, w, 3'b010);
			ahb_read(CRC_IDR, {24'h0, w[7:0]});
		end
		crc_ahb_checker_i.test_done("IDR scratch");

		if (crc_ahb_checker_i.expect_q.size() != 0)
			$display("%0d expected reads never completed", crc_ahb_checker_i.expect_q.size());
		$display("Checks: %0d passed, %0d failed", crc_ahb_checker_i.pass_count,
		         crc_ahb_checker_i.fail_count + aborted);
		if (crc_ahb_checker_i.fail_count == 0 && !aborted && crc_ahb_checker_i.expect_q.size() == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- compile.f
logic/crc_ahb_pkg.sv
logic/crc_byte_stream_if.sv
logic/host_interface.sv
logic/crc_input_buffer.sv
logic/crc_engine.sv
logic/crc_ahb_top.sv
verification/crc_ahb_checker.sv
verification/crc_ahb_tb.sv

//--- Bender.yml
package:
  name: crc_ahb

sources:
  - files:
      - logic/crc_ahb_pkg.sv
      - logic/crc_byte_stream_if.sv
      - logic/host_interface.sv
      - logic/crc_input_buffer.sv
      - logic/crc_engine.sv
      - logic/crc_ahb_top.sv
  - target: test
    files:
      - verification/crc_ahb_checker.sv
      - verification/crc_ahb_tb.sv
